// ==== logic/board_pkg.sv ====
package board_pkg;

    localparam int game_w = 5; // game select width, 32 codes

    // supported titles, codes 8..31 fall to the default board
    typedef enum logic [game_w-1:0] {
        game_finalb   = 5'd0, // pcr palette board
        game_dondokod = 5'd1, // roz layer title
        game_megab    = 5'd2,
        game_cameltry = 5'd3, // roz plus paddle
        game_growl    = 5'd4, // extra io chip and mcu
        game_dinorex  = 5'd5, // object extender, second rom
        game_gunfront = 5'd6, // swapped inputs
        game_qjinsei  = 5'd7  // object extender
    } game_t;

    // chip population flags for the selected board
    typedef struct packed {
        logic       pri360;       // priority mixer present
        logic       pcr110;       // palette chip instead of palette ram
        logic       dar260;       // dual-roz capable tile chip
        logic       fmc190;       // sound/mcu chip
        logic [1:0] obj_extender; // object code extension mode
        logic       io_swap;      // player input swap
        logic       tmp82c265;    // alternate io controller
    } features_t;

    // most boards carry priority and roz support
    localparam features_t features_default = '{
        pri360:       1'b1,
        pcr110:       1'b0,
        dar260:       1'b1,
        fmc190:       1'b0,
        obj_extender: 2'b00,
        io_swap:      1'b0,
        tmp82c265:    1'b0
    };

    localparam features_t features_reset = '{
        pri360:       1'b0,
        pcr110:       1'b0,
        dar260:       1'b0,
        fmc190:       1'b0,
        obj_extender: 2'b00,
        io_swap:      1'b0,
        tmp82c265:    1'b0
    };

endpackage

// ==== logic/memmap_pkg.sv ====
package memmap_pkg;

    // one decode window, compared against cpu addr[23:16]
    typedef struct packed {
        logic [7:0] base; // window start, addr[23:16]
        logic [7:0] mask; // 1 bits take part in the compare
    } region_t;

    // base ff with a zero mask never gets selected by the decoder
    localparam region_t region_unmapped = '{
        base: 8'hff,
        mask: 8'h00
    };

    // slot of each window in the region table
    typedef enum logic [3:0] {
        region_rom       = 4'd0,  // main program rom
        region_rom1      = 4'd1,  // second program rom bank
        region_work_ram  = 4'd2,  // cpu work ram
        region_screen    = 4'd3,  // tilemap chip ram
        region_obj       = 4'd4,  // sprite ram
        region_color     = 4'd5,  // palette ram or pcr chip
        region_io0       = 4'd6,  // primary io chip
        region_io1       = 4'd7,  // secondary io window
        region_sound     = 4'd8,  // sound comm port
        region_extension = 4'd9,  // object extender / spritebank
        region_priority  = 4'd10, // priority mixer regs
        region_roz       = 4'd11  // rotate/zoom layer ram
    } region_e;

    localparam int num_regions = 12;

    // full table, indexed by region_e
    typedef region_t [num_regions-1:0] region_map_t;

endpackage

// ==== logic/board_features.sv ====
`timescale 1ns/1ps

module board_features (
    input  logic                 clk,
    input  logic                 arst_n,
    input  board_pkg::game_t     game,
    output board_pkg::features_t features
);

    import board_pkg::*;

    features_t features_next; // decoded flags ahead of the register

    // start from the common board, patch per title
    always_comb begin
        features_next = features_default;
        case (game)
            game_finalb: begin
                features_next.pri360 = 1'b0; // no priority mixer
                features_next.dar260 = 1'b0;
                features_next.pcr110 = 1'b1; // palette via pcr chip
            end
            game_dinorex: begin
                features_next.obj_extender = 2'b01; // extended sprite codes
            end
            game_qjinsei: begin
                features_next.obj_extender = 2'b01; // same extender as dinorex
            end
            game_gunfront: begin
                features_next.io_swap = 1'b1; // inputs wired swapped
            end
            game_growl: begin
                features_next.tmp82c265 = 1'b1; // alt io controller
                features_next.fmc190    = 1'b1; // mcu on board
            end
            default: ; // other titles and unknown codes keep the default set
        endcase
    end

    // one cycle from game to flags
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            features <= features_reset; // all flags clear
        end else begin
            features <= features_next;
        end
    end

endmodule

// ==== logic/board_memmap.sv ====
`timescale 1ns/1ps

module board_memmap (
    input  logic                    clk,
    input  logic                    arst_n,
    input  board_pkg::game_t        game,
    output memmap_pkg::region_map_t regions
);

    import board_pkg::*;
    import memmap_pkg::*;

    region_map_t regions_next; // decoded table ahead of the register

    always_comb begin
        // anything a title does not list stays unmapped
        for (int i = 0; i < num_regions; i++) begin
            regions_next[i] = region_unmapped;
        end

        case (game)
            game_finalb: begin
                regions_next[region_rom]      = '{8'h00, 8'hfc}; // 256k program
                regions_next[region_work_ram] = '{8'h10, 8'hff};
                regions_next[region_color]    = '{8'h20, 8'hff}; // pcr regs
                regions_next[region_io0]      = '{8'h30, 8'hff};
                regions_next[region_sound]    = '{8'h32, 8'hff};
                regions_next[region_screen]   = '{8'h80, 8'hf0};
                regions_next[region_obj]      = '{8'h90, 8'hff};
            end

            game_dondokod: begin
                regions_next[region_rom]      = '{8'h00, 8'hf8}; // 512k program
                regions_next[region_work_ram] = '{8'h10, 8'hff};
                regions_next[region_color]    = '{8'h20, 8'hff}; // palette ram
                regions_next[region_io0]      = '{8'h30, 8'hff};
                regions_next[region_sound]    = '{8'h32, 8'hff};
                regions_next[region_screen]   = '{8'h80, 8'hf0};
                regions_next[region_obj]      = '{8'h90, 8'hff};
                regions_next[region_roz]      = '{8'ha0, 8'hfe}; // a0..a1
                regions_next[region_priority] = '{8'hb0, 8'hff};
            end

            game_megab: begin
                regions_next[region_rom]      = '{8'h00, 8'hf8};
                regions_next[region_sound]    = '{8'h10, 8'hff}; // sound sits low here
                regions_next[region_io0]      = '{8'h12, 8'hff};
                regions_next[region_work_ram] = '{8'h20, 8'hff};
                regions_next[region_color]    = '{8'h30, 8'hff};
                regions_next[region_priority] = '{8'h40, 8'hff};
                regions_next[region_screen]   = '{8'h60, 8'hf0};
                regions_next[region_obj]      = '{8'h80, 8'hff};
            end

            game_cameltry: begin
                regions_next[region_rom]      = '{8'h00, 8'hfc};
                regions_next[region_work_ram] = '{8'h10, 8'hff};
                regions_next[region_color]    = '{8'h20, 8'hff};
                regions_next[region_io0]      = '{8'h30, 8'hff}; // paddle shares this
                regions_next[region_sound]    = '{8'h32, 8'hff};
                regions_next[region_screen]   = '{8'h80, 8'hf0};
                regions_next[region_obj]      = '{8'h90, 8'hff};
                regions_next[region_roz]      = '{8'ha0, 8'hff}; // single page
                regions_next[region_priority] = '{8'hd0, 8'hff};
            end

            game_growl: begin
                regions_next[region_rom]       = '{8'h00, 8'hf0}; // 1M program
                regions_next[region_work_ram]  = '{8'h10, 8'hff};
                regions_next[region_color]     = '{8'h20, 8'hff};
                regions_next[region_io0]       = '{8'h30, 8'hff}; // dsw and coin
                regions_next[region_io1]       = '{8'h32, 8'hff}; // player inputs
                regions_next[region_sound]     = '{8'h40, 8'hff};
                regions_next[region_extension] = '{8'h50, 8'hff}; // spritebank, inputs 3/4
                regions_next[region_screen]    = '{8'h80, 8'hf0};
                regions_next[region_obj]       = '{8'h90, 8'hff};
                regions_next[region_priority]  = '{8'hb0, 8'hff};
            end

            game_dinorex: begin
                regions_next[region_rom]       = '{8'h00, 8'he0}; // 2M program
                regions_next[region_rom1]      = '{8'h20, 8'hf0}; // extra 1M bank
                regions_next[region_io0]       = '{8'h30, 8'hff};
                regions_next[region_extension] = '{8'h40, 8'hff}; // object extender ram
                regions_next[region_color]     = '{8'h50, 8'hff};
                regions_next[region_work_ram]  = '{8'h60, 8'hf0};
                regions_next[region_priority]  = '{8'h70, 8'hff};
                regions_next[region_obj]       = '{8'h80, 8'hff};
                regions_next[region_screen]    = '{8'h90, 8'hf0};
                regions_next[region_sound]     = '{8'ha0, 8'hff};
            end

            game_gunfront: begin
                regions_next[region_rom]      = '{8'h00, 8'hf0};
                regions_next[region_work_ram] = '{8'h10, 8'hff};
                regions_next[region_color]    = '{8'h20, 8'hff};
                regions_next[region_io0]      = '{8'h30, 8'hff};
                regions_next[region_sound]    = '{8'h32, 8'hff};
                regions_next[region_screen]   = '{8'h80, 8'hf0};
                regions_next[region_obj]      = '{8'h90, 8'hff};
                regions_next[region_priority] = '{8'hb0, 8'hff};
            end

            game_qjinsei: begin
                regions_next[region_rom]       = '{8'h00, 8'he0};
                regions_next[region_sound]     = '{8'h20, 8'hff};
                regions_next[region_work_ram]  = '{8'h30, 8'hff};
                regions_next[region_extension] = '{8'h60, 8'hfc}; // 60..63
                regions_next[region_color]     = '{8'h70, 8'hff};
                regions_next[region_screen]    = '{8'h80, 8'hf0};
                regions_next[region_obj]       = '{8'h90, 8'hff};
                regions_next[region_priority]  = '{8'ha0, 8'hff};
                regions_next[region_io0]       = '{8'hb0, 8'hff}; // io at the top
            end

            default: ; // unknown title, table stays unmapped
        endcase
    end

    // registered table, decoder sees it one cycle after game
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            regions <= {num_regions{region_unmapped}}; // nothing decodes in reset
        end else begin
            regions <= regions_next;
        end
    end

endmodule

// ==== logic/board_config.sv ====
`timescale 1ns/1ps

module board_config (
    input  logic             clk,
    input  logic             arst_n,
    input  board_pkg::game_t game,

    output logic             cfg_360pri,
    output logic             cfg_110pcr,
    output logic             cfg_260dar,
    output logic             cfg_190fmc,
    output logic [1:0]       cfg_obj_extender,
    output logic             cfg_io_swap,
    output logic             cfg_tmp82c265,

    output logic [15:0]      cfg_addr_rom,
    output logic [15:0]      cfg_addr_rom1,
    output logic [15:0]      cfg_addr_work_ram,
    output logic [15:0]      cfg_addr_screen,
    output logic [15:0]      cfg_addr_obj,
    output logic [15:0]      cfg_addr_color,
    output logic [15:0]      cfg_addr_io0,
    output logic [15:0]      cfg_addr_io1,
    output logic [15:0]      cfg_addr_sound,
    output logic [15:0]      cfg_addr_extension,
    output logic [15:0]      cfg_addr_priority,
    output logic [15:0]      cfg_addr_roz
);

    import board_pkg::*;
    import memmap_pkg::*;

    features_t   features; // registered chip flags
    region_map_t regions;  // registered decode table

    board_features u_features (
        .clk      (clk),
        .arst_n   (arst_n),
        .game     (game),
        .features (features)
    );

    board_memmap u_memmap (
        .clk     (clk),
        .arst_n  (arst_n),
        .game    (game),
        .regions (regions)
    );

    // flag struct out to single bits
    assign cfg_360pri       = features.pri360;
    assign cfg_110pcr       = features.pcr110;
    assign cfg_260dar       = features.dar260;
    assign cfg_190fmc       = features.fmc190;
    assign cfg_obj_extender = features.obj_extender;
    assign cfg_io_swap      = features.io_swap;
    assign cfg_tmp82c265    = features.tmp82c265;

    // each entry is {base, mask}
    assign cfg_addr_rom       = regions[region_rom];
    assign cfg_addr_rom1      = regions[region_rom1];
    assign cfg_addr_work_ram  = regions[region_work_ram];
    assign cfg_addr_screen    = regions[region_screen];
    assign cfg_addr_obj       = regions[region_obj];
    assign cfg_addr_color     = regions[region_color];
    assign cfg_addr_io0       = regions[region_io0];
    assign cfg_addr_io1       = regions[region_io1];
    assign cfg_addr_sound     = regions[region_sound];
    assign cfg_addr_extension = regions[region_extension];
    assign cfg_addr_priority  = regions[region_priority];
    assign cfg_addr_roz       = regions[region_roz];

endmodule

// ==== tb/board_config_assert.sv ====
`timescale 1ns/1ps

module board_config_assert (
    input logic                                   clk,
    input logic                                   arst_n,
    input board_pkg::game_t                       game,
    input logic [7:0]                             flags, // 360pri down to tmp82c265
    input logic [16*memmap_pkg::num_regions-1:0]  addr   // rom in the low 16 bits
);

    import memmap_pkg::*;

    // full tables, slot order rom rom1 work_ram screen obj color io0 io1 sound ext pri roz
    localparam logic [15:0] finalb_map [num_regions] = '{
        16'h00fc, 16'hff00, 16'h10ff, 16'h80f0, 16'h90ff, 16'h20ff,
        16'h30ff, 16'hff00, 16'h32ff, 16'hff00, 16'hff00, 16'hff00
    };
    localparam logic [15:0] growl_map [num_regions] = '{
        16'h00f0, 16'hff00, 16'h10ff, 16'h80f0, 16'h90ff, 16'h20ff,
        16'h30ff, 16'h32ff, 16'h40ff, 16'h50ff, 16'hb0ff, 16'hff00
    };
    localparam logic [15:0] dinorex_map [num_regions] = '{
        16'h00e0, 16'h20f0, 16'h60f0, 16'h90f0, 16'h80ff, 16'h50ff,
        16'h30ff, 16'hff00, 16'ha0ff, 16'h40ff, 16'h70ff, 16'hff00
    };

    logic [4:0]                         game_prev; // code at the last edge
    logic                               live_prev; // reset was off at the last edge
    logic [8+16*num_regions-1:0]        outs_prev; // all outputs at the last edge
    int unsigned                        fail_count = 0; // watched by the testbench

    // flag byte per code, unknown codes get pri360 and dar260
    function automatic logic [7:0] flags_for(input logic [4:0] code);
        case (code)
            5'd0:    return 8'h40; // pcr only
            5'd4:    return 8'hb1; // plus fmc190 and tmp82c265
            5'd5,
            5'd7:    return 8'ha4; // extender mode 1
            5'd6:    return 8'ha2; // io swap
            default: return 8'ha0;
        endcase
    endfunction

    // {checked, entry} for one slot
    function automatic logic [16:0] addr_for(input logic [4:0] code, input int idx);
        if (code > 5'd7) begin
            return {1'b1, 16'hff00}; // unknown board maps nothing
        end
        case (code)
            5'd0:    return {1'b1, finalb_map[idx]};
            5'd4:    return {1'b1, growl_map[idx]};
            5'd5:    return {1'b1, dinorex_map[idx]};
            default: begin
                if (idx == 1 || idx == 7) begin
                    return {1'b1, 16'hff00}; // rom1 and io1 unused here
                end
                if (idx == 11 && code != 5'd1 && code != 5'd3) begin
                    return {1'b1, 16'hff00}; // roz only on dondokod and cameltry
                end
                return 17'h0; // slot not checked
            end
        endcase
    endfunction

    function automatic string slot_name(input int idx);
        case (idx)
            0:       return "cfg_addr_rom";
            1:       return "cfg_addr_rom1";
            2:       return "cfg_addr_work_ram";
            3:       return "cfg_addr_screen";
            4:       return "cfg_addr_obj";
            5:       return "cfg_addr_color";
            6:       return "cfg_addr_io0";
            7:       return "cfg_addr_io1";
            8:       return "cfg_addr_sound";
            9:       return "cfg_addr_extension";
            10:      return "cfg_addr_priority";
            default: return "cfg_addr_roz";
        endcase
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            live_prev <= 1'b0;
            game_prev <= 5'd0;
            outs_prev <= '0;
        end else begin
            live_prev <= 1'b1;
            game_prev <= game;
            outs_prev <= {flags, addr};
        end
    end

    flags_in_reset: assert property (@(posedge clk) !arst_n |-> flags == 8'h00)
        else begin
            fail_count++;
            $error("error cfg flags got %h exp %h", $sampled(flags), 8'h00);
        end

    flags_follow_code: assert property (@(posedge clk) disable iff (!arst_n)
        live_prev |-> flags == flags_for(game_prev))
        else begin
            fail_count++;
            $error("error cfg flags got %h exp %h", $sampled(flags),
                   flags_for($sampled(game_prev)));
        end

    // same code on two edges, nothing may move
    outputs_hold: assert property (@(posedge clk) disable iff (!arst_n)
        live_prev && game == game_prev |=> {flags, addr} == outs_prev)
        else begin
            fail_count++;
            $error("error cfg outputs got %h exp %h", $sampled({flags, addr}),
                   $sampled(outs_prev));
        end

    for (genvar i = 0; i < num_regions; i++) begin : g_slot
        logic [15:0] slot;     // this port's entry
        logic [16:0] slot_exp; // {checked, expected}

        assign slot     = addr[16*i +: 16];
        assign slot_exp = addr_for(game_prev, i);

        slot_in_reset: assert property (@(posedge clk) !arst_n |-> slot == 16'hff00)
            else begin
                fail_count++;
                $error("error %s got %h exp %h", slot_name(i), $sampled(slot), 16'hff00);
            end

        slot_follows_code: assert property (@(posedge clk) disable iff (!arst_n)
            live_prev && slot_exp[16] |-> slot == slot_exp[15:0])
            else begin
                fail_count++;
                $error("error %s got %h exp %h", slot_name(i), $sampled(slot),
                       $sampled(slot_exp[15:0]));
            end
    end

endmodule

bind board_config board_config_assert u_checks (
    .clk    (clk),
    .arst_n (arst_n),
    .game   (game),
    .flags  ({cfg_360pri, cfg_110pcr, cfg_260dar, cfg_190fmc,
              cfg_obj_extender, cfg_io_swap, cfg_tmp82c265}),
    .addr   ({cfg_addr_roz, cfg_addr_priority, cfg_addr_extension, cfg_addr_sound,
              cfg_addr_io1, cfg_addr_io0, cfg_addr_color, cfg_addr_obj,
              cfg_addr_screen, cfg_addr_work_ram, cfg_addr_rom1, cfg_addr_rom})
);

// ==== tb/tb_board_config.sv ====
`timescale 1ns/1ps

module tb_board_config;

    import board_pkg::*;

    localparam int clk_period   = 4; // ns
    localparam int reset_cycles = 5;
    localparam int hold_cycles  = 3; // per directed code
    localparam int random_codes = 40;
    // reset margin, ten directed codes, random codes, drain
    localparam int run_cycles   = 10 + hold_cycles * 10 + random_codes + 20;

    logic        clk;
    logic        arst_n;
    game_t       game;
    int          seed; // $random state

    logic        cfg_360pri;
    logic        cfg_110pcr;
    logic        cfg_260dar;
    logic        cfg_190fmc;
    logic [1:0]  cfg_obj_extender;
    logic        cfg_io_swap;
    logic        cfg_tmp82c265;
    logic [15:0] cfg_addr_rom;
    logic [15:0] cfg_addr_rom1;
    logic [15:0] cfg_addr_work_ram;
    logic [15:0] cfg_addr_screen;
    logic [15:0] cfg_addr_obj;
    logic [15:0] cfg_addr_color;
    logic [15:0] cfg_addr_io0;
    logic [15:0] cfg_addr_io1;
    logic [15:0] cfg_addr_sound;
    logic [15:0] cfg_addr_extension;
    logic [15:0] cfg_addr_priority;
    logic [15:0] cfg_addr_roz;

    board_config u_dut (.*);

    always #(clk_period / 2) clk = ~clk;

    // called 1 ns after an edge, leaves 1 ns after the last held edge
    task automatic hold_code(input logic [4:0] code, input int cycles);
        game = game_t'(code);
        repeat (cycles) @(posedge clk);
        #1;
    endtask

    initial begin
        logic [4:0] code;

        clk    = 1'b0;
        arst_n = 1'b1; // high first, so the async reset sees a falling edge
        game   = game_finalb;
        seed   = 32'h96c1;
        #1;
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // every title, then both ends of the unknown range
        for (int c = 0; c < 8; c++) begin
            hold_code(5'(c), hold_cycles);
        end
        hold_code(5'd8, hold_cycles);
        hold_code(5'd31, hold_cycles);

        for (int n = 0; n < random_codes; n++) begin
            code = 5'($random(seed));
            hold_code(code, 1); // new code every edge
        end

        repeat (3) @(posedge clk); // let the last checks fire
        #1;
        if (u_dut.u_checks.fail_count == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Simulation finished: FAIL");
            $fatal(1, "%0d assertion failures", u_dut.u_checks.fail_count);
        end
    end

    // stop at the first failed assertion
    initial begin
        wait (u_dut.u_checks.fail_count != 0);
        $display("Simulation finished: FAIL");
        $fatal(1, "an assertion on the DUT outputs failed");
    end

    initial begin
        #(run_cycles * clk_period);
        $display("Simulation finished: FAIL");
        $fatal(1, "run did not finish within %0d cycles", run_cycles);
    end

endmodule

// ==== sources.f ====
logic/board_pkg.sv
logic/memmap_pkg.sv
logic/board_features.sv
logic/board_memmap.sv
logic/board_config.sv
tb/board_config_assert.sv
tb/tb_board_config.sv

// ==== Makefile ====
TOP := tb_board_config

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f sources.f --Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir
